// File: exe_stage.f
+incdir+source
source/exe_pkg.sv
source/exe_lane.sv
source/exe_dcache_req.sv
source/exe_mem_reg.sv
source/exe_stage.sv
tb/exe_stage_asserts.sv
tb/exe_stage_tb.sv

// File: run.sh
#!/bin/sh
set -e

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module exe_stage_tb -f exe_stage.f -o exe_stage_sim

# a nonzero exit from the simulator also ends the script
./obj_dir/exe_stage_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0

// File: source/exe_dcache_req.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_dcache_req (
    input  wire                    dcache_pause_i,
    input  wire  [1:0]             valid_i,     // lanes holding a memory op
    input  exe_pkg::alu_op_e       aluop0_i,
    input  exe_pkg::alu_op_e       aluop1_i,
    input  wire  [`EXE_XLEN-1:0]   addr0_i,
    input  wire  [`EXE_XLEN-1:0]   addr1_i,
    input  wire  [`EXE_XLEN-1:0]   data0_i,
    input  wire  [`EXE_XLEN-1:0]   data1_i,
    output logic [`EXE_STRB_W-1:0] ren_o,
    output logic [`EXE_STRB_W-1:0] wstrb_o,
    output logic [`EXE_XLEN-1:0]   vaddr_o,
    output logic [`EXE_XLEN-1:0]   wdata_o
);

    exe_pkg::alu_op_e     sel_op;
    logic [`EXE_XLEN-1:0] sel_addr;
    logic [`EXE_XLEN-1:0] sel_data;

    // lane 0 first
    assign sel_op   = valid_i[0] ? aluop0_i : aluop1_i;
    assign sel_addr = valid_i[0] ? addr0_i : addr1_i;
    assign sel_data = valid_i[0] ? data0_i : data1_i;

    always_comb begin
        ren_o   = '0;
        wstrb_o = '0;
        vaddr_o = '0;
        wdata_o = '0;
        if (!dcache_pause_i && (|valid_i)) begin
            vaddr_o = sel_addr;
            case (sel_op)
                exe_pkg::OP_LD_W: ren_o = '1;
                exe_pkg::OP_ST_W: begin
                    wstrb_o = '1;
                    wdata_o = sel_data;
                end
                exe_pkg::OP_ST_B: begin
                    wstrb_o[sel_addr[1:0]] = 1'b1;
                    wdata_o = {(`EXE_XLEN / 8){sel_data[7:0]}};  // byte on every lane
                end
                default: vaddr_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/exe_lane.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_lane (
    input  wire                       valid_i,
    input  exe_pkg::alu_op_e          aluop_i,
    input  wire  [`EXE_XLEN-1:0]      pc_i,
    input  wire  [`EXE_XLEN-1:0]      src_a_i,
    input  wire  [`EXE_XLEN-1:0]      src_b_i,
    input  wire  [`EXE_XLEN-1:0]      imm_i,
    output logic [`EXE_XLEN-1:0]      result_o,
    output logic [`EXE_XLEN-1:0]      addr_o,
    output logic [`EXE_XLEN-1:0]      store_data_o,
    output logic [`EXE_XLEN-1:0]      target_o,
    output logic                      taken_o,
    output logic                      is_mem_o
);

    logic [`EXE_XLEN-1:0] alu_res;
    logic [`EXE_XLEN-1:0] br_target;
    logic                 br_taken;
    logic                 mem_op;
    logic [4:0]           shamt;

    assign shamt = src_b_i[4:0];

    always_comb begin
        alu_res   = '0;
        br_target = '0;
        br_taken  = 1'b0;
        mem_op    = 1'b0;
        case (aluop_i)
            exe_pkg::OP_ADD:  alu_res = src_a_i + src_b_i;
            exe_pkg::OP_SUB:  alu_res = src_a_i - src_b_i;
            exe_pkg::OP_AND:  alu_res = src_a_i & src_b_i;
            exe_pkg::OP_OR:   alu_res = src_a_i | src_b_i;
            exe_pkg::OP_XOR:  alu_res = src_a_i ^ src_b_i;
            exe_pkg::OP_SLT:  alu_res[0] = $signed(src_a_i) < $signed(src_b_i);
            exe_pkg::OP_SLTU: alu_res[0] = src_a_i < src_b_i;
            exe_pkg::OP_SLL:  alu_res = src_a_i << shamt;
            exe_pkg::OP_SRL:  alu_res = src_a_i >> shamt;
            exe_pkg::OP_SRA:  alu_res = $signed(src_a_i) >>> shamt;
            exe_pkg::OP_BEQ: begin
                br_taken  = src_a_i == src_b_i;
                br_target = pc_i + imm_i;
            end
            exe_pkg::OP_BNE: begin
                br_taken  = src_a_i != src_b_i;
                br_target = pc_i + imm_i;
            end
            exe_pkg::OP_BLT: begin
                br_taken  = $signed(src_a_i) < $signed(src_b_i);
                br_target = pc_i + imm_i;
            end
            exe_pkg::OP_BGE: begin
                br_taken  = $signed(src_a_i) >= $signed(src_b_i);
                br_target = pc_i + imm_i;
            end
            exe_pkg::OP_B: begin
                br_taken  = 1'b1;
                br_target = pc_i + imm_i;
            end
            exe_pkg::OP_JIRL: begin
                br_taken  = 1'b1;
                br_target = src_a_i + imm_i;
                alu_res   = pc_i + `EXE_LINK_OFFSET;  // link
            end
            exe_pkg::OP_LD_W,
            exe_pkg::OP_ST_W,
            exe_pkg::OP_ST_B: mem_op = 1'b1;
            default: ;
        endcase
    end

    // nothing leaves an idle lane
    assign result_o     = valid_i ? alu_res : '0;
    assign taken_o      = valid_i & br_taken;
    assign target_o     = valid_i ? br_target : '0;
    assign is_mem_o     = valid_i & mem_op;
    assign addr_o       = (valid_i & mem_op) ? src_a_i + imm_i : '0;
    assign store_data_o = (valid_i & mem_op) ? src_b_i : '0;

endmodule

`default_nettype wire

// File: source/exe_mem_reg.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_mem_reg (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     flush_i,
    input  wire                     pause_i,
    input  wire                     pause_mem_i,
    input  wire  [1:0]              valid_i,
    input  wire                     taken0_i,
    input  wire                     taken1_i,
    input  wire  [`EXE_XLEN-1:0]    target0_i,
    input  wire  [`EXE_XLEN-1:0]    target1_i,
    input  wire  [`EXE_XLEN-1:0]    pc0_i,
    input  wire  [`EXE_XLEN-1:0]    pc1_i,
    input  exe_pkg::alu_op_e        aluop0_i,
    input  exe_pkg::alu_op_e        aluop1_i,
    input  wire  [1:0]              rd_we_i,
    input  wire  [`EXE_REG_AW-1:0]  rd_addr0_i,
    input  wire  [`EXE_REG_AW-1:0]  rd_addr1_i,
    input  wire  [`EXE_XLEN-1:0]    result0_i,
    input  wire  [`EXE_XLEN-1:0]    result1_i,
    input  wire  [`EXE_XLEN-1:0]    addr0_i,
    input  wire  [`EXE_XLEN-1:0]    addr1_i,
    input  wire  [`EXE_XLEN-1:0]    data0_i,
    input  wire  [`EXE_XLEN-1:0]    data1_i,
    output logic                    branch_flush_o,
    output logic [`EXE_XLEN-1:0]    branch_target_o,
    output logic [1:0]              mem_valid_o,
    output logic [`EXE_XLEN-1:0]    mem_pc0_o,
    output logic [`EXE_XLEN-1:0]    mem_pc1_o,
    output exe_pkg::alu_op_e        mem_aluop0_o,
    output exe_pkg::alu_op_e        mem_aluop1_o,
    output logic [1:0]              mem_rd_we_o,
    output logic [`EXE_REG_AW-1:0]  mem_rd_addr0_o,
    output logic [`EXE_REG_AW-1:0]  mem_rd_addr1_o,
    output logic [`EXE_XLEN-1:0]    mem_rd_data0_o,
    output logic [`EXE_XLEN-1:0]    mem_rd_data1_o,
    output logic [`EXE_XLEN-1:0]    mem_addr0_o,
    output logic [`EXE_XLEN-1:0]    mem_addr1_o,
    output logic [`EXE_XLEN-1:0]    mem_data0_o,
    output logic [`EXE_XLEN-1:0]    mem_data1_o
);

    logic       squash1;
    logic [1:0] we_q;

    // lane 0 branch kills lane 1
    assign squash1 = taken0_i;
    assign we_q    = rd_we_i & valid_i;

    assign branch_flush_o  = (taken0_i | taken1_i) & ~pause_mem_i;
    assign branch_target_o = taken0_i ? target0_i : target1_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            mem_valid_o    <= '0;
            mem_pc0_o      <= '0;
            mem_pc1_o      <= '0;
            mem_aluop0_o   <= exe_pkg::OP_NOP;
            mem_aluop1_o   <= exe_pkg::OP_NOP;
            mem_rd_we_o    <= '0;
            mem_rd_addr0_o <= '0;
            mem_rd_addr1_o <= '0;
            mem_rd_data0_o <= '0;
            mem_rd_data1_o <= '0;
            mem_addr0_o    <= '0;
            mem_addr1_o    <= '0;
            mem_data0_o    <= '0;
            mem_data1_o    <= '0;
        end else if (!pause_i) begin  // pause holds every field
            mem_valid_o    <= {valid_i[1] & ~squash1, valid_i[0]};
            mem_rd_we_o    <= {we_q[1] & ~squash1, we_q[0]};
            mem_pc0_o      <= pc0_i;
            mem_pc1_o      <= pc1_i;
            mem_aluop0_o   <= aluop0_i;
            mem_aluop1_o   <= aluop1_i;
            mem_rd_addr0_o <= rd_addr0_i;
            mem_rd_addr1_o <= rd_addr1_i;
            mem_rd_data0_o <= result0_i;
            mem_rd_data1_o <= result1_i;
            mem_addr0_o    <= addr0_i;
            mem_addr1_o    <= addr1_i;
            mem_data0_o    <= data0_i;
            mem_data1_o    <= data1_i;
        end
    end

endmodule

`default_nettype wire

// File: source/exe_pkg.sv
`default_nettype none

package exe_pkg;

    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        // integer alu
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_OR   = 5'd4,
        OP_XOR  = 5'd5,
        OP_SLT  = 5'd6,
        OP_SLTU = 5'd7,
        OP_SLL  = 5'd8,
        OP_SRL  = 5'd9,
        OP_SRA  = 5'd10,
        // conditional branches, target pc + imm
        OP_BEQ  = 5'd11,
        OP_BNE  = 5'd12,
        OP_BLT  = 5'd13,
        OP_BGE  = 5'd14,
        // unconditional
        OP_B    = 5'd15,
        OP_JIRL = 5'd16,  // register indirect, links pc + 4
        // memory ops
        OP_LD_W = 5'd17,
        OP_ST_W = 5'd18,
        OP_ST_B = 5'd19
    } alu_op_e;

endpackage

`default_nettype wire

// File: source/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath and address width
`define EXE_XLEN 32

// register file address width
`define EXE_REG_AW 5

// link value for jirl is pc plus this
`define EXE_LINK_OFFSET 4

// one strobe bit per byte of a data word
`define EXE_STRB_W 4

`endif

// File: source/exe_stage.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_stage (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     flush_i,
    input  wire                     pause_i,
    input  wire                     pause_mem_i,
    input  wire                     dcache_pause_i,
    input  wire  [1:0]              valid_i,
    input  wire  [`EXE_XLEN-1:0]    pc0_i,
    input  wire  [`EXE_XLEN-1:0]    pc1_i,
    input  exe_pkg::alu_op_e        aluop0_i,
    input  exe_pkg::alu_op_e        aluop1_i,
    input  wire  [`EXE_XLEN-1:0]    src_a0_i,
    input  wire  [`EXE_XLEN-1:0]    src_b0_i,
    input  wire  [`EXE_XLEN-1:0]    src_a1_i,
    input  wire  [`EXE_XLEN-1:0]    src_b1_i,
    input  wire  [`EXE_XLEN-1:0]    imm0_i,
    input  wire  [`EXE_XLEN-1:0]    imm1_i,
    input  wire  [1:0]              rd_we_i,
    input  wire  [`EXE_REG_AW-1:0]  rd_addr0_i,
    input  wire  [`EXE_REG_AW-1:0]  rd_addr1_i,
    output wire  [`EXE_STRB_W-1:0]  ren_o,
    output wire  [`EXE_STRB_W-1:0]  wstrb_o,
    output wire  [`EXE_XLEN-1:0]    vaddr_o,
    output wire  [`EXE_XLEN-1:0]    wdata_o,
    output wire  [1:0]              fwd_we_o,
    output wire  [`EXE_REG_AW-1:0]  fwd_addr0_o,
    output wire  [`EXE_REG_AW-1:0]  fwd_addr1_o,
    output wire  [`EXE_XLEN-1:0]    fwd_data0_o,
    output wire  [`EXE_XLEN-1:0]    fwd_data1_o,
    output wire                     branch_flush_o,
    output wire  [`EXE_XLEN-1:0]    branch_target_o,
    output wire  [1:0]              mem_valid_o,
    output wire  [`EXE_XLEN-1:0]    mem_pc0_o,
    output wire  [`EXE_XLEN-1:0]    mem_pc1_o,
    output exe_pkg::alu_op_e        mem_aluop0_o,
    output exe_pkg::alu_op_e        mem_aluop1_o,
    output wire  [1:0]              mem_rd_we_o,
    output wire  [`EXE_REG_AW-1:0]  mem_rd_addr0_o,
    output wire  [`EXE_REG_AW-1:0]  mem_rd_addr1_o,
    output wire  [`EXE_XLEN-1:0]    mem_rd_data0_o,
    output wire  [`EXE_XLEN-1:0]    mem_rd_data1_o,
    output wire  [`EXE_XLEN-1:0]    mem_addr0_o,
    output wire  [`EXE_XLEN-1:0]    mem_addr1_o,
    output wire  [`EXE_XLEN-1:0]    mem_data0_o,
    output wire  [`EXE_XLEN-1:0]    mem_data1_o
);

    wire [`EXE_XLEN-1:0] result0, addr0, data0, target0;
    wire [`EXE_XLEN-1:0] result1, addr1, data1, target1;
    wire                 taken0, taken1;
    wire                 is_mem0, is_mem1;

    exe_lane u_lane0 (
        .valid_i(valid_i[0]), .aluop_i(aluop0_i), .pc_i(pc0_i),
        .src_a_i(src_a0_i), .src_b_i(src_b0_i), .imm_i(imm0_i),
        .result_o(result0), .addr_o(addr0), .store_data_o(data0),
        .target_o(target0), .taken_o(taken0), .is_mem_o(is_mem0)
    );

    exe_lane u_lane1 (
        .valid_i(valid_i[1]), .aluop_i(aluop1_i), .pc_i(pc1_i),
        .src_a_i(src_a1_i), .src_b_i(src_b1_i), .imm_i(imm1_i),
        .result_o(result1), .addr_o(addr1), .store_data_o(data1),
        .target_o(target1), .taken_o(taken1), .is_mem_o(is_mem1)
    );

    // write-back values back to dispatch, same cycle
    assign fwd_we_o    = rd_we_i & valid_i;
    assign fwd_addr0_o = valid_i[0] ? rd_addr0_i : '0;
    assign fwd_addr1_o = valid_i[1] ? rd_addr1_i : '0;
    assign fwd_data0_o = result0;
    assign fwd_data1_o = result1;

    exe_dcache_req u_dcache_req (
        .dcache_pause_i(dcache_pause_i), .valid_i({is_mem1, is_mem0}),
        .aluop0_i(aluop0_i), .aluop1_i(aluop1_i),
        .addr0_i(addr0), .addr1_i(addr1), .data0_i(data0), .data1_i(data1),
        .ren_o(ren_o), .wstrb_o(wstrb_o), .vaddr_o(vaddr_o), .wdata_o(wdata_o)
    );

    exe_mem_reg u_mem_reg (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i),
        .pause_i(pause_i), .pause_mem_i(pause_mem_i),
        .valid_i(valid_i), .taken0_i(taken0), .taken1_i(taken1),
        .target0_i(target0), .target1_i(target1), .pc0_i(pc0_i), .pc1_i(pc1_i),
        .aluop0_i(aluop0_i), .aluop1_i(aluop1_i), .rd_we_i(rd_we_i),
        .rd_addr0_i(rd_addr0_i), .rd_addr1_i(rd_addr1_i),
        .result0_i(result0), .result1_i(result1),
        .addr0_i(addr0), .addr1_i(addr1), .data0_i(data0), .data1_i(data1),
        .branch_flush_o(branch_flush_o), .branch_target_o(branch_target_o),
        .mem_valid_o(mem_valid_o), .mem_pc0_o(mem_pc0_o), .mem_pc1_o(mem_pc1_o),
        .mem_aluop0_o(mem_aluop0_o), .mem_aluop1_o(mem_aluop1_o),
        .mem_rd_we_o(mem_rd_we_o),
        .mem_rd_addr0_o(mem_rd_addr0_o), .mem_rd_addr1_o(mem_rd_addr1_o),
        .mem_rd_data0_o(mem_rd_data0_o), .mem_rd_data1_o(mem_rd_data1_o),
        .mem_addr0_o(mem_addr0_o), .mem_addr1_o(mem_addr1_o),
        .mem_data0_o(mem_data0_o), .mem_data1_o(mem_data1_o)
    );

endmodule

`default_nettype wire

// File: tb/exe_stage_asserts.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_stage_asserts (
    input wire                    clk,
    input wire                    reset_i,
    input wire                    flush_i,
    input wire                    pause_i,
    input wire                    pause_mem_i,
    input wire                    dcache_pause_i,
    input wire  [1:0]             valid_i,
    input wire  [`EXE_XLEN-1:0]   pc0_i, pc1_i, src_a0_i, src_b0_i, src_a1_i, src_b1_i,
    input wire  [`EXE_XLEN-1:0]   imm0_i, imm1_i,
    input exe_pkg::alu_op_e       aluop0_i, aluop1_i, mem_aluop0_o, mem_aluop1_o,
    input wire  [1:0]             rd_we_i, fwd_we_o, mem_valid_o, mem_rd_we_o,
    input wire  [`EXE_REG_AW-1:0] rd_addr0_i, rd_addr1_i, fwd_addr0_o, fwd_addr1_o,
    input wire  [`EXE_REG_AW-1:0] mem_rd_addr0_o, mem_rd_addr1_o,
    input wire  [`EXE_STRB_W-1:0] ren_o, wstrb_o,
    input wire  [`EXE_XLEN-1:0]   vaddr_o, wdata_o, fwd_data0_o, fwd_data1_o,
    input wire                    branch_flush_o,
    input wire  [`EXE_XLEN-1:0]   branch_target_o, mem_pc0_o, mem_pc1_o,
    input wire  [`EXE_XLEN-1:0]   mem_rd_data0_o, mem_rd_data1_o, mem_addr0_o, mem_addr1_o,
    input wire  [`EXE_XLEN-1:0]   mem_data0_o, mem_data1_o
);

    int unsigned err_cnt = 0;  // read by the testbench

    function automatic logic [`EXE_XLEN-1:0] alu_ref(exe_pkg::alu_op_e op,
            logic [`EXE_XLEN-1:0] pc, logic [`EXE_XLEN-1:0] a, logic [`EXE_XLEN-1:0] b);
        case (op)
            exe_pkg::OP_ADD:  return a + b;
            exe_pkg::OP_SUB:  return a - b;
            exe_pkg::OP_AND:  return a & b;
            exe_pkg::OP_OR:   return a | b;
            exe_pkg::OP_XOR:  return a ^ b;
            exe_pkg::OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
            exe_pkg::OP_SLTU: return {31'd0, a < b};
            exe_pkg::OP_SLL:  return a << b[4:0];
            exe_pkg::OP_SRL:  return a >> b[4:0];
            exe_pkg::OP_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            exe_pkg::OP_JIRL: return pc + `EXE_LINK_OFFSET;
            default:          return '0;
        endcase
    endfunction

    function automatic logic taken_ref(exe_pkg::alu_op_e op,
            logic [`EXE_XLEN-1:0] a, logic [`EXE_XLEN-1:0] b);
        case (op)
            exe_pkg::OP_BEQ:  return a == b;
            exe_pkg::OP_BNE:  return a != b;
            exe_pkg::OP_BLT:  return $signed(a) < $signed(b);
            exe_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            exe_pkg::OP_B, exe_pkg::OP_JIRL: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic is_mem(exe_pkg::alu_op_e op);
        return op == exe_pkg::OP_LD_W || op == exe_pkg::OP_ST_W || op == exe_pkg::OP_ST_B;
    endfunction

    logic [`EXE_XLEN-1:0]   exp_res0, exp_res1, exp_tgt;
    logic                   exp_tk0, exp_tk1, exp_flush, captured, held;
    logic                   lane_mem0, lane_mem1;
    logic [1:0]             exp_mem_valid, exp_mem_we;
    logic [`EXE_STRB_W-1:0] exp_ren, exp_wstrb;
    logic [`EXE_XLEN-1:0]   exp_vaddr, exp_wdata;
    logic [279:0]           mem_bus;
    logic [85:0]            cap_exp, cap_got;  // pcs, opcodes, write enables, rd addresses
    logic [2*`EXE_XLEN-1:0] exp_ad0, exp_ad1;
    logic [75:0]            exp_fwd;

    assign exp_res0 = valid_i[0] ? alu_ref(aluop0_i, pc0_i, src_a0_i, src_b0_i) : '0;
    assign exp_res1 = valid_i[1] ? alu_ref(aluop1_i, pc1_i, src_a1_i, src_b1_i) : '0;
    assign exp_tk0  = valid_i[0] & taken_ref(aluop0_i, src_a0_i, src_b0_i);
    assign exp_tk1  = valid_i[1] & taken_ref(aluop1_i, src_a1_i, src_b1_i);
    assign exp_tgt  = exp_tk0 ? ((aluop0_i == exe_pkg::OP_JIRL) ? src_a0_i : pc0_i) + imm0_i
                              : ((aluop1_i == exe_pkg::OP_JIRL) ? src_a1_i : pc1_i) + imm1_i;
    assign exp_flush     = (exp_tk0 | exp_tk1) & ~pause_mem_i;
    assign exp_mem_valid = {valid_i[1] & ~exp_tk0, valid_i[0]};
    assign exp_mem_we    = {rd_we_i[1] & valid_i[1] & ~exp_tk0, rd_we_i[0] & valid_i[0]};
    assign lane_mem0 = valid_i[0] & is_mem(aluop0_i);
    assign lane_mem1 = valid_i[1] & is_mem(aluop1_i);
    assign exp_ad0   = {src_a0_i + imm0_i, src_b0_i};
    assign exp_ad1   = {src_a1_i + imm1_i, src_b1_i};
    assign captured = !reset_i && !flush_i && !pause_i;
    assign held     = pause_i && !reset_i && !flush_i;
    assign mem_bus  = {mem_valid_o, mem_rd_we_o, mem_aluop0_o, mem_aluop1_o, mem_rd_addr0_o,
                       mem_rd_addr1_o, mem_pc0_o, mem_pc1_o, mem_rd_data0_o, mem_rd_data1_o,
                       mem_addr0_o, mem_addr1_o, mem_data0_o, mem_data1_o};
    assign cap_exp  = {pc0_i, pc1_i, aluop0_i, aluop1_i, exp_mem_we,
                       rd_addr0_i, rd_addr1_i};
    assign cap_got  = {mem_pc0_o, mem_pc1_o, mem_aluop0_o, mem_aluop1_o, mem_rd_we_o,
                       mem_rd_addr0_o, mem_rd_addr1_o};
    assign exp_fwd  = {rd_we_i & valid_i, valid_i[0] ? rd_addr0_i : 5'd0,
                       valid_i[1] ? rd_addr1_i : 5'd0, exp_res0, exp_res1};

    always_comb begin
        exe_pkg::alu_op_e     op_s;
        logic [`EXE_XLEN-1:0] addr_s;
        logic [`EXE_XLEN-1:0] data_s;
        op_s   = lane_mem0 ? aluop0_i : aluop1_i;
        addr_s = lane_mem0 ? src_a0_i + imm0_i : src_a1_i + imm1_i;
        data_s = lane_mem0 ? src_b0_i : src_b1_i;
        exp_ren   = '0;
        exp_wstrb = '0;
        exp_vaddr = '0;
        exp_wdata = '0;
        if (!dcache_pause_i && (lane_mem0 || lane_mem1)) begin
            exp_vaddr = addr_s;
            if (op_s == exe_pkg::OP_LD_W) exp_ren = '1;
            if (op_s == exe_pkg::OP_ST_W) begin
                exp_wstrb = '1;
                exp_wdata = data_s;
            end
            if (op_s == exe_pkg::OP_ST_B) begin
                exp_wstrb = `EXE_STRB_W'(1) << addr_s[1:0];
                exp_wdata = {(`EXE_XLEN / 8){data_s[7:0]}};
            end
        end
    end

    a_data0: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured) |-> mem_rd_data0_o == $past(exp_res0))
        else begin
            err_cnt++;
            $error("ERR %0t mem_rd_data0_o exp %h got %h",
                $time, $past(exp_res0), mem_rd_data0_o);
        end
    a_data1: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured) |-> mem_rd_data1_o == $past(exp_res1))
        else begin
            err_cnt++;
            $error("ERR %0t mem_rd_data1_o exp %h got %h",
                $time, $past(exp_res1), mem_rd_data1_o);
        end
    a_valid: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured) |-> mem_valid_o == $past(exp_mem_valid))
        else begin
            err_cnt++;
            $error("ERR %0t mem_valid_o exp %b got %b",
                $time, $past(exp_mem_valid), mem_valid_o);
        end
    a_capture: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured) |-> cap_got == $past(cap_exp))
        else begin
            err_cnt++;
            $error("ERR %0t mem_pc/mem_aluop/mem_rd_we_o/mem_rd_addr exp %h got %h",
                $time, $past(cap_exp), cap_got);
        end
    a_maddr0: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured && lane_mem0) |-> {mem_addr0_o, mem_data0_o} == $past(exp_ad0))
        else begin
            err_cnt++;
            $error("ERR %0t mem_addr0_o/mem_data0_o exp %h got %h",
                $time, $past(exp_ad0), {mem_addr0_o, mem_data0_o});
        end
    a_maddr1: assert property (@(posedge clk) disable iff (reset_i)
        $past(captured && lane_mem1) |-> {mem_addr1_o, mem_data1_o} == $past(exp_ad1))
        else begin
            err_cnt++;
            $error("ERR %0t mem_addr1_o/mem_data1_o exp %h got %h",
                $time, $past(exp_ad1), {mem_addr1_o, mem_data1_o});
        end
    a_clear: assert property (@(posedge clk)
        (reset_i || flush_i) |=> mem_valid_o == 2'b00 && mem_rd_we_o == 2'b00)
        else begin
            err_cnt++;
            $error("ERR %0t mem_valid_o/mem_rd_we_o exp 0 got %b/%b",
                $time, mem_valid_o, mem_rd_we_o);
        end
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
        $past(held) |-> mem_bus == $past(mem_bus))
        else begin
            err_cnt++;
            $error("ERR %0t mem_ outputs exp %h got %h", $time, $past(mem_bus), mem_bus);
        end
    a_flush: assert property (@(posedge clk) disable iff (reset_i)
        branch_flush_o == exp_flush)
        else begin
            err_cnt++;
            $error("ERR %0t branch_flush_o exp %b got %b", $time, exp_flush, branch_flush_o);
        end
    a_target: assert property (@(posedge clk) disable iff (reset_i)
        (exp_tk0 || exp_tk1) |-> branch_target_o == exp_tgt)
        else begin
            err_cnt++;
            $error("ERR %0t branch_target_o exp %h got %h", $time, exp_tgt, branch_target_o);
        end
    a_cache: assert property (@(posedge clk) disable iff (reset_i)
        {ren_o, wstrb_o, vaddr_o, wdata_o} == {exp_ren, exp_wstrb, exp_vaddr, exp_wdata})
        else begin
            err_cnt++;
            $error("ERR %0t ren/wstrb/vaddr/wdata exp %h got %h", $time,
                {exp_ren, exp_wstrb, exp_vaddr, exp_wdata}, {ren_o, wstrb_o, vaddr_o, wdata_o});
        end
    a_fwd: assert property (@(posedge clk) disable iff (reset_i)
        {fwd_we_o, fwd_addr0_o, fwd_addr1_o, fwd_data0_o, fwd_data1_o} == exp_fwd)
        else begin
            err_cnt++;
            $error("ERR %0t fwd_we_o/fwd_addr0_o/fwd_addr1_o/fwd_data0_o/fwd_data1_o exp %h got %h",
                $time, exp_fwd, {fwd_we_o, fwd_addr0_o, fwd_addr1_o, fwd_data0_o, fwd_data1_o});
        end

endmodule

bind exe_stage exe_stage_asserts u_asserts (.*);

`default_nettype wire

// File: tb/exe_stage_tb.sv
`timescale 1ns/1ps
`include "exe_settings.svh"
`default_nettype none

module exe_stage_tb;

    logic                    clk;
    logic                    reset_i, flush_i, pause_i, pause_mem_i, dcache_pause_i;
    logic [1:0]              valid_i, rd_we_i;
    logic [`EXE_XLEN-1:0]    pc0_i, pc1_i, src_a0_i, src_b0_i, src_a1_i, src_b1_i;
    logic [`EXE_XLEN-1:0]    imm0_i, imm1_i;
    exe_pkg::alu_op_e        aluop0_i, aluop1_i, mem_aluop0_o, mem_aluop1_o;
    logic [`EXE_REG_AW-1:0]  rd_addr0_i, rd_addr1_i;
    wire  [`EXE_STRB_W-1:0]  ren_o, wstrb_o;
    wire  [`EXE_XLEN-1:0]    vaddr_o, wdata_o, fwd_data0_o, fwd_data1_o, branch_target_o;
    wire  [1:0]              fwd_we_o, mem_valid_o, mem_rd_we_o;
    wire  [`EXE_REG_AW-1:0]  fwd_addr0_o, fwd_addr1_o, mem_rd_addr0_o, mem_rd_addr1_o;
    wire                     branch_flush_o;
    wire  [`EXE_XLEN-1:0]    mem_pc0_o, mem_pc1_o, mem_rd_data0_o, mem_rd_data1_o;
    wire  [`EXE_XLEN-1:0]    mem_addr0_o, mem_addr1_o, mem_data0_o, mem_data1_o;

    integer seed;
    int     seen_flush, seen_stb, seen_hold, seen_squash;

    exe_stage DUT (.*);

    always #5 clk = ~clk;

    function automatic logic mem_op(exe_pkg::alu_op_e op);
        return op >= exe_pkg::OP_LD_W;
    endfunction

    function automatic exe_pkg::alu_op_e pick_op();
        return exe_pkg::alu_op_e'(5'($unsigned($random(seed)) % 20));
    endfunction

    // one random instruction pair, applied on the falling edge
    task automatic drive_random();
        @(negedge clk);
        // outputs here still belong to the pair of the last cycle
        if (branch_flush_o) seen_flush++;
        if (wstrb_o != 0 && wstrb_o != 4'hf) seen_stb++;
        if (pause_i && !flush_i) seen_hold++;
        if (valid_i == 2'b11 && aluop0_i >= exe_pkg::OP_B && aluop0_i <= exe_pkg::OP_JIRL
            && !pause_i && !flush_i)
            seen_squash++;
        valid_i  = 2'($random(seed));
        aluop0_i = pick_op();
        aluop1_i = pick_op();
        if (mem_op(aluop0_i) && mem_op(aluop1_i))
            aluop1_i = exe_pkg::OP_ADD;  // one memory op per cycle
        pc0_i    = {$random(seed)} & 32'hffff_fffc;
        pc1_i    = pc0_i + 4;
        src_a0_i = $random(seed);
        src_a1_i = $random(seed);
        src_b0_i = ($random(seed) & 3) == 0 ? src_a0_i : $random(seed);  // hit equal compares
        src_b1_i = ($random(seed) & 3) == 0 ? src_a1_i : $random(seed);
        imm0_i   = $random(seed);
        imm1_i   = $random(seed);
        rd_we_i    = 2'($random(seed));
        rd_addr0_i = 5'($random(seed));
        rd_addr1_i = 5'($random(seed));
        flush_i        = ($random(seed) & 15) == 0;
        pause_i        = ($random(seed) & 7) == 0;
        pause_mem_i    = ($random(seed) & 7) == 0;
        dcache_pause_i = ($random(seed) & 7) == 0;
    endtask

    // assertion failures stop the run here
    always @(negedge clk) begin
        if (DUT.u_asserts.err_cnt != 0) begin
            $display("Simulation failed");
            $fatal(1, "assertion failure in exe_stage");
        end
    end

    initial begin
        int cycles;
        seed = 32'hb2362dc6;
        clk = 1'b0;
        reset_i = 1'b1;
        flush_i = 1'b0;
        pause_i = 1'b0;
        pause_mem_i = 1'b0;
        dcache_pause_i = 1'b0;
        valid_i = '0;
        rd_we_i = '0;
        aluop0_i = exe_pkg::OP_NOP;
        aluop1_i = exe_pkg::OP_NOP;
        {pc0_i, pc1_i, src_a0_i, src_b0_i, src_a1_i, src_b1_i, imm0_i, imm1_i} = '0;
        rd_addr0_i = '0;
        rd_addr1_i = '0;
        {seen_flush, seen_stb, seen_hold, seen_squash} = '0;

        cycles = 0;
        while (cycles < 10) begin  // reset for 10 cycles
            @(negedge clk);
            cycles++;
        end
        reset_i = 1'b0;

        // random traffic until every rule has been exercised
        cycles = 0;
        while (cycles < 2000 || seen_flush < 20 || seen_stb < 10 || seen_hold < 20
               || seen_squash < 10) begin
            drive_random();
            cycles++;
            if (cycles > 20000) begin
                $display("timeout: random stimulus never reached every check");
                $display("Simulation failed");
                $fatal(1, "stimulus timeout");
            end
        end

        @(negedge clk);
        valid_i = '0;
        @(negedge clk);
        if (DUT.u_asserts.err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
